/* Makefile */
TOP := cpu8_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f cpu8.f --top-module cpu8_top
	verilator --lint-only --timing -f cpu8.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f cpu8.f --top-module $(TOP) --Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* cpu8.f */
+incdir+design
design/cpu8_pkg.sv
design/word_select_mux.sv
design/reg_file.sv
design/alu8.sv
design/cpu8_ctrl.sv
design/cpu8_top.sv
tests/cpu8_tb.sv

/* design/alu8.sv */
`timescale 1ns/100ps
`default_nettype none

module alu8
   import cpu8_pkg::*;
(
   input  wire ctrl_t  ctrl,
   input  wire word_t  a,
   input  wire word_t  b,
   input  wire word_t  imm,
   output word_t       y,
   output flags_t      flags
);

   localparam int W = $bits(word_t);

   // Second operand after the immediate/register choice
   word_t        op_b;
   // Extended result, top bit is carry out or borrow
   logic [W:0]   sum;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Two-way operand select as AND-OR gating
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign op_b = (imm & {W{ctrl.use_imm}}) | (b & {W{~ctrl.use_imm}});

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Function and flags
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      sum         = '0;
      y           = op_b;
      flags.carry = 1'b0;
      case (ctrl.alu_op)
         // LDI and MOV pass B through
         ALU_PASS_B: y = op_b;
         ALU_ADD: begin
            sum         = {1'b0, a} + {1'b0, op_b};
            y           = sum[W-1:0];
            flags.carry = sum[W];
         end
         ALU_SUB: begin
            // Wraps negative when op_b > a, top bit becomes the borrow
            sum         = {1'b0, a} - {1'b0, op_b};
            y           = sum[W-1:0];
            flags.carry = sum[W];
         end
         // Logic ops leave carry cleared
         ALU_AND: y = a & op_b;
         ALU_OR:  y = a | op_b;
         ALU_XOR: y = a ^ op_b;
         default: y = op_b;
      endcase
      // Zero flag tracks the 8-bit result for every function
      flags.zero = ~|y;
   end

endmodule

`default_nettype wire

/* design/cpu8_consts.svh */
`ifndef CPU8_CONSTS_SVH
`define CPU8_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed sizes of the 8-bit register machine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Datapath word width
`define CPU8_DATA_W 8

// Register file depth
`define CPU8_NREGS 16

// Register index width, log2 of the depth
`define CPU8_RIDX_W 4

`endif

/* design/cpu8_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu8_ctrl
   import cpu8_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   reset,
   input  wire logic   instr_valid,
   input  wire instr_t instr,
   input  wire flags_t alu_flags,
   input  wire word_t  a_data,
   output ctrl_t       ctrl,
   output logic        out_valid,
   output result_t     out
);

   phase_t phase;
   // Stored zero and carry
   flags_t flags_q;
   // Strobe accepted only once running
   logic   strobe;
   logic   is_out;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Phase FSM
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (reset) begin
         phase <= PH_RESET;
      end else begin
         // One cycle in PH_RESET after reset drops, then run for good
         phase <= PH_RUN;
      end
   end

   assign strobe = instr_valid && (phase == PH_RUN);
   assign is_out = strobe && (instr.opcode == OP_OUT);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Opcode decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      ctrl = '{alu_op: ALU_PASS_B, use_imm: 1'b0, reg_we: 1'b0, flag_we: 1'b0};
      case (instr.opcode)
         OP_LDI: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_we  = strobe;
         end
         // Plain copy, flags untouched
         OP_MOV: ctrl.reg_we = strobe;
         OP_ADD: ctrl = '{alu_op: ALU_ADD, use_imm: 1'b0, reg_we: strobe, flag_we: strobe};
         OP_SUB: ctrl = '{alu_op: ALU_SUB, use_imm: 1'b0, reg_we: strobe, flag_we: strobe};
         OP_AND: ctrl = '{alu_op: ALU_AND, use_imm: 1'b0, reg_we: strobe, flag_we: strobe};
         OP_OR:  ctrl = '{alu_op: ALU_OR,  use_imm: 1'b0, reg_we: strobe, flag_we: strobe};
         OP_XOR: ctrl = '{alu_op: ALU_XOR, use_imm: 1'b0, reg_we: strobe, flag_we: strobe};
         // OUT reads rd only
         OP_OUT: ctrl.reg_we = 1'b0;
         default: ctrl.reg_we = 1'b0;
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Flags and OUT report
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (reset) begin
         flags_q   <= '0;
         out_valid <= 1'b0;
      end else begin
         if (ctrl.flag_we) begin
            flags_q <= alu_flags;
         end
         out_valid <= is_out;
      end
   end

   // Report payload, flags as they stood before this edge
   always_ff @(posedge clk) begin
      if (is_out) begin
         out <= '{data: a_data, flags: flags_q};
      end
   end

   // Every report traces back to a strobe one cycle earlier
   assert property (@(posedge clk) disable iff (reset)
                    out_valid |-> $past(instr_valid))
      else $error("cpu8_ctrl: out_valid without a preceding strobe");

   // A two-cycle report needs two consecutive strobes
   assert property (@(posedge clk) disable iff (reset)
                    (out_valid && $past(out_valid)) |->
                    ($past(instr_valid) && $past(instr_valid, 2)))
      else $error("cpu8_ctrl: out_valid held without back-to-back strobes");

endmodule

`default_nettype wire

/* design/cpu8_pkg.sv */
`default_nettype none

`include "cpu8_consts.svh"

package cpu8_pkg;

   // Datapath word and register index
   typedef logic [`CPU8_DATA_W-1:0] word_t;
   typedef logic [`CPU8_RIDX_W-1:0] ridx_t;

   // Instruction opcodes, as carried in the strobed word
   typedef enum logic [2:0] {
      OP_LDI = 3'd0,
      OP_MOV = 3'd1,
      OP_ADD = 3'd2,
      OP_SUB = 3'd3,
      OP_AND = 3'd4,
      OP_OR  = 3'd5,
      OP_XOR = 3'd6,
      OP_OUT = 3'd7
   } opcode_t;

   // 19-bit instruction word
   typedef struct packed {
      opcode_t opcode;
      ridx_t   rd;
      ridx_t   rs;
      word_t   imm;
   } instr_t;

   // ALU function select
   typedef enum logic [2:0] {
      ALU_PASS_B = 3'd0,
      ALU_ADD    = 3'd1,
      ALU_SUB    = 3'd2,
      ALU_AND    = 3'd3,
      ALU_OR     = 3'd4,
      ALU_XOR    = 3'd5
   } alu_op_t;

   // Decoded controls for one instruction
   typedef struct packed {
      alu_op_t alu_op;
      logic    use_imm;   // B operand from the immediate
      logic    reg_we;    // Write ALU result to rd
      logic    flag_we;   // Update zero and carry
   } ctrl_t;

   typedef struct packed {
      logic zero;
      logic carry;
   } flags_t;

   // OUT report
   typedef struct packed {
      word_t  data;
      flags_t flags;
   } result_t;

   // Reset and run phase of the control unit
   typedef enum logic {
      PH_RESET = 1'b0,
      PH_RUN   = 1'b1
   } phase_t;

endpackage

`default_nettype wire

/* design/cpu8_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu8_top
   import cpu8_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   reset,
   input  wire logic   instr_valid,
   input  wire instr_t instr,
   output logic        out_valid,
   output result_t     out
);

   // Decoded controls for the strobed instruction
   ctrl_t  ctrl;
   // Register read data, A from rd and B from rs
   word_t  a_data;
   word_t  b_data;
   // ALU result and its flags
   word_t  alu_y;
   flags_t alu_flags;

   cpu8_ctrl ctrl_unit (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .alu_flags   (alu_flags),
      .a_data      (a_data),
      .ctrl        (ctrl),
      .out_valid   (out_valid),
      .out         (out)
   );

   // rd is both a source and the destination
   reg_file regs (
      .clk    (clk),
      .reset  (reset),
      .we     (ctrl.reg_we),
      .wa     (instr.rd),
      .ra     (instr.rd),
      .rb     (instr.rs),
      .wd     (alu_y),
      .a_data (a_data),
      .b_data (b_data)
   );

   alu8 alu (
      .ctrl  (ctrl),
      .a     (a_data),
      .b     (b_data),
      .imm   (instr.imm),
      .y     (alu_y),
      .flags (alu_flags)
   );

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_consts.svh"

module reg_file (
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire logic                    we,
   input  wire logic [`CPU8_RIDX_W-1:0] wa,
   input  wire logic [`CPU8_RIDX_W-1:0] ra,
   input  wire logic [`CPU8_RIDX_W-1:0] rb,
   input  wire logic [`CPU8_DATA_W-1:0] wd,
   output logic      [`CPU8_DATA_W-1:0] a_data,
   output logic      [`CPU8_DATA_W-1:0] b_data
);

   // Sixteen 8-bit registers, flat for the selectors
   logic [`CPU8_NREGS-1:0][`CPU8_DATA_W-1:0] regs;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Write port
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (reset) begin
         // Machine state starts all zero
         regs <= '0;
      end else if (we) begin
         regs[wa] <= wd;
      end
   end

   // Read port A, addressed by rd
   word_select_mux mux_a (
      .sel   (ra),
      .words (regs),
      .y     (a_data)
   );

   // Read port B, addressed by rs
   word_select_mux mux_b (
      .sel   (rb),
      .words (regs),
      .y     (b_data)
   );

   // Control must hold off writes until it leaves reset
   assert property (@(posedge clk) reset |-> (we !== 1'b1))
      else $error("reg_file: write enable asserted during reset");

endmodule

`default_nettype wire

/* design/word_select_mux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_consts.svh"

module word_select_mux (
   input  wire logic [`CPU8_RIDX_W-1:0]                  sel,
   input  wire logic [`CPU8_NREGS-1:0][`CPU8_DATA_W-1:0] words,
   output logic      [`CPU8_DATA_W-1:0]                  y
);

   // True and complement select rails
   logic [`CPU8_RIDX_W-1:0]                  sel_n;
   // One-hot select lines, one per word
   logic [`CPU8_NREGS-1:0]                   line;
   // Words after gating with their line
   logic [`CPU8_NREGS-1:0][`CPU8_DATA_W-1:0] plane;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Decode into one-hot lines
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      logic [`CPU8_RIDX_W-1:0] code;
      sel_n = ~sel;
      for (int i = 0; i < `CPU8_NREGS; i++) begin
         code = `CPU8_RIDX_W'(i);
         // Each term takes the true rail where the code bit is 1, else complement
         line[i] = &((sel & code) | (sel_n & ~code));
      end
      // Known select must light exactly one line
      if (!$isunknown(sel)) begin
         assert ($onehot(line))
            else $error("word_select_mux: select lines not one-hot for sel %0d", sel);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // AND plane then OR plane
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      y = '0;
      for (int i = 0; i < `CPU8_NREGS; i++) begin
         // Line fanned out across the word
         plane[i] = words[i] & {`CPU8_DATA_W{line[i]}};
         y        = y | plane[i];
      end
   end

endmodule

`default_nettype wire

/* tests/cpu8_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_consts.svh"

module cpu8_tb
   import cpu8_pkg::*;
();

   // About seven times the cycles spent by all tests together
   localparam int CYCLE_LIMIT = 2000;

   logic    clk = 1'b0;
   logic    reset;
   logic    instr_valid;
   instr_t  instr;
   logic    out_valid;
   result_t out;

   // Reference model state
   word_t   mregs [`CPU8_NREGS];
   flags_t  mflags;
   logic [31:0] rng = 32'd58;
   int      cycles = 0;
   string   test_name;

   cpu8_top DUT (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .out_valid   (out_valid),
      .out         (out)
   );

   always #50 clk = ~clk;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Failure, timeout and random source
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic stop_on_error();
      $display("tests failed");
      $fatal(1, "stopping at first error");
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run exceeded %0d cycles without finishing", CYCLE_LIMIT);
         stop_on_error();
      end
   end

   // xorshift32, advances the shared state
   function logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic check_result(input string name, input result_t exp, input result_t act);
      if (exp !== act) begin
         $display("FAILED %s: expected data %02h z %b c %b, actual data %02h z %b c %b",
                  name, exp.data, exp.flags.zero, exp.flags.carry,
                  act.data, act.flags.zero, act.flags.carry);
         stop_on_error();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("FAILED %s: expected %b actual %b", name, exp, act);
         stop_on_error();
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model and drivers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic instr_t make_instr(input opcode_t op, input ridx_t rd, input ridx_t rs,
                                         input word_t imm);
      return '{opcode: op, rd: rd, rs: rs, imm: imm};
   endfunction

   task automatic model_step(input instr_t i);
      word_t a;
      word_t b;
      word_t res;
      logic  cy;
      a   = mregs[i.rd];
      b   = mregs[i.rs];
      res = '0;
      cy  = 1'b0;
      case (i.opcode)
         OP_LDI: mregs[i.rd] = i.imm;
         OP_MOV: mregs[i.rd] = b;
         OP_ADD: begin
            res = a + b;
            cy  = (int'(a) + int'(b)) > 255;
         end
         // Borrow when the subtrahend is larger
         OP_SUB: begin
            res = a - b;
            cy  = b > a;
         end
         OP_AND: res = a & b;
         OP_OR:  res = a | b;
         OP_XOR: res = a ^ b;
         default: ;
      endcase
      if (i.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR}) begin
         mregs[i.rd] = res;
         mflags      = '{zero: (res == '0), carry: cy};
      end
   endtask

   // One strobe at the falling edge, checked one cycle later
   task automatic issue(input instr_t i);
      result_t exp;
      exp         = '{data: mregs[i.rd], flags: mflags};
      instr       = i;
      instr_valid = 1'b1;
      @(posedge clk);
      @(negedge clk);
      model_step(i);
      if (i.opcode == OP_OUT) begin
         check_bit({test_name, " out_valid"}, 1'b1, out_valid);
         check_result(test_name, exp, out);
      end else if (out_valid !== 1'b0) begin
         $display("%s: out_valid was raised after an instruction that is not OUT", test_name);
         stop_on_error();
      end
   endtask

   task automatic do_out(input ridx_t r);
      issue(make_instr(OP_OUT, r, '0, '0));
   endtask

   task automatic idle(input int n);
      instr_valid = 1'b0;
      repeat (n) begin
         @(posedge clk);
         @(negedge clk);
         if (out_valid !== 1'b0) begin
            $display("%s: out_valid was raised with no strobe present", test_name);
            stop_on_error();
         end
      end
   endtask

   // Three reset cycles, then the PH_RESET cycle; strobes optional throughout
   task automatic apply_reset(input logic with_strobe);
      instr_valid = 1'b0;
      reset       = 1'b1;
      @(negedge clk);
      instr       = make_instr(OP_LDI, 4'd5, '0, 8'ha5);
      instr_valid = with_strobe;
      repeat (2) @(negedge clk);
      reset = 1'b0;
      instr = make_instr(OP_LDI, 4'd6, '0, 8'h3c);
      @(negedge clk);
      instr_valid = 1'b0;
      for (int r = 0; r < `CPU8_NREGS; r++) mregs[r] = '0;
      mflags = '0;
   endtask

   // Load two distinct registers, apply op, report rd
   task automatic run_pair(input opcode_t op, input word_t x, input word_t y);
      ridx_t rd;
      ridx_t rs;
      rd = ridx_t'(next_rand());
      rs = rd + ridx_t'(1 + next_rand() % 15);
      issue(make_instr(OP_LDI, rd, '0, x));
      issue(make_instr(OP_LDI, rs, '0, y));
      issue(make_instr(op, rd, rs, '0));
      do_out(rd);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Directed tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic test_reset_state();
      test_name = "reset_state";
      idle(4);
      for (int r = 0; r < `CPU8_NREGS; r++) do_out(ridx_t'(r));
      idle(2);
   endtask

   task automatic test_ldi_all();
      test_name = "ldi_all";
      for (int r = 0; r < `CPU8_NREGS; r++) issue(make_instr(OP_LDI, ridx_t'(r), '0,
                                                              word_t'(next_rand())));
      // Sweeps every select of port A
      for (int r = 0; r < `CPU8_NREGS; r++) do_out(ridx_t'(r));
      idle(1);
   endtask

   task automatic test_mov();
      test_name = "mov";
      issue(make_instr(OP_LDI, 4'd3, '0, word_t'(next_rand())));
      idle(1);
      issue(make_instr(OP_MOV, 4'd7, 4'd3, '0));
      do_out(4'd7);
      // LDI then MOV then OUT on consecutive cycles
      issue(make_instr(OP_LDI, 4'd1, '0, word_t'(next_rand())));
      issue(make_instr(OP_MOV, 4'd2, 4'd1, '0));
      do_out(4'd2);
      // Port B sweep, every register copied into r0 and reported
      for (int r = 0; r < `CPU8_NREGS; r++) begin
         issue(make_instr(OP_MOV, '0, ridx_t'(r), '0));
         do_out('0);
      end
      idle(1);
   endtask

   task automatic test_add_sub();
      test_name = "add_sub";
      run_pair(OP_ADD, 8'hff, 8'h01);
      run_pair(OP_SUB, 8'h00, 8'h01);
      run_pair(OP_SUB, 8'h5a, 8'h5a);
      run_pair(OP_ADD, 8'h80, 8'h80);
      for (int k = 0; k < 12; k++) begin
         run_pair((k % 2 == 0) ? OP_ADD : OP_SUB, word_t'(next_rand()), word_t'(next_rand()));
      end
      idle(1);
   endtask

   task automatic test_logic_flags();
      opcode_t ops [3];
      test_name = "logic_flags";
      ops = '{OP_AND, OP_OR, OP_XOR};
      for (int k = 0; k < 12; k++) begin
         // Leave carry set so the logic op has something to clear
         run_pair(OP_ADD, 8'hff, 8'hff);
         run_pair(ops[k % 3], word_t'(next_rand()), word_t'(next_rand()));
      end
      // LDI and MOV keep zero and carry from the ADD
      run_pair(OP_ADD, 8'hff, 8'h01);
      issue(make_instr(OP_LDI, 4'd9, '0, 8'h42));
      issue(make_instr(OP_MOV, 4'd10, 4'd9, '0));
      do_out(4'd10);
      idle(1);
   endtask

   task automatic test_reset_write();
      test_name = "reset_write";
      apply_reset(1'b1);
      idle(1);
      do_out(4'd5);
      do_out(4'd6);
      idle(1);
   endtask

   initial begin
      reset       = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      apply_reset(1'b0);
      test_reset_state();
      test_ldi_all();
      test_mov();
      test_add_sub();
      test_logic_flags();
      test_reset_write();
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire
